/* rtl/muldiv_defs.svh */
`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

// Data word width of operands and results
`define MULDIV_XLEN 32

// One quotient or product bit is produced per iteration
`define MULDIV_ITER `MULDIV_XLEN

// Counter must hold values up to MULDIV_ITER-1
`define MULDIV_CNT_W 6

`endif

/* rtl/muldiv_pkg.sv */
`default_nettype none

`include "muldiv_defs.svh"

package muldiv_pkg;

    typedef logic [`MULDIV_XLEN-1:0]   xlen_t;   // Operand or result word
    typedef logic [2*`MULDIV_XLEN-1:0] dxlen_t;  // Full product
    typedef logic [`MULDIV_CNT_W-1:0]  cnt_t;    // Iteration counter

    // Encoded as the RISC-V funct3 field of the M extension
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } muldiv_op_e;

    typedef struct packed {
        muldiv_op_e op;
        xlen_t      a;       // rs1, dividend or multiplicand
        xlen_t      b;       // rs2, divisor or multiplier
    } muldiv_req_t;

    typedef struct packed {
        xlen_t result;
        logic  div_zero;     // Result came from a division by zero
    } muldiv_rsp_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_CALC,
        DIV_FIX
    } div_state_e;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_CALC,
        MUL_FIX
    } mul_state_e;

endpackage

`default_nettype wire

/* rtl/div_mc.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_defs.svh"

module div_mc import muldiv_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  start,
    input  xlen_t dividend,
    input  xlen_t divisor,
    input  logic  signed_op,
    input  logic  want_rem,
    output logic  busy,
    output logic  done,
    output xlen_t result,
    output logic  div_zero
);

    localparam xlen_t MIN_NEG = {1'b1, {(`MULDIV_XLEN-1){1'b0}}};

    div_state_e state;
    cnt_t       count;

    xlen_t dvd_q;                       // Dividend bits leave at the top, quotient bits enter below
    xlen_t dvs_q;                       // Divisor magnitude
    xlen_t rem_q;                       // Partial remainder
    logic  q_neg;                       // Quotient needs negation
    logic  r_neg;                       // Remainder needs negation
    logic  rem_sel;
    logic  zero_q;

    xlen_t dvd_abs;
    xlen_t dvs_abs;
    logic  is_zero;
    logic  is_ovf;

    logic [`MULDIV_XLEN:0] rem_sh;      // One extra bit so the shift cannot overflow
    logic [`MULDIV_XLEN:0] trial;

    always_comb begin
        dvd_abs = (signed_op && dividend[`MULDIV_XLEN-1]) ? -dividend : dividend;
        dvs_abs = (signed_op && divisor[`MULDIV_XLEN-1]) ? -divisor : divisor;
        is_zero = (divisor == '0);
        is_ovf  = signed_op && (dividend == MIN_NEG) && (divisor == '1);
    end

    // Shift in the next dividend bit first, then try the subtraction
    always_comb begin
        rem_sh = {rem_q, dvd_q[`MULDIV_XLEN-1]};
        trial  = rem_sh - {1'b0, dvs_q};    // Top bit set means the divisor did not fit
    end

    assign busy = (state != DIV_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= DIV_IDLE;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    count <= '0;
                    if (start) begin
                        state <= (is_zero || is_ovf) ? DIV_FIX : DIV_CALC;
                    end
                end
                DIV_CALC: begin
                    count <= count + 1'b1;
                    if (count == cnt_t'(`MULDIV_ITER - 1)) begin
                        state <= DIV_FIX;
                    end
                end
                DIV_FIX: begin
                    done  <= 1'b1;                  // Single cycle pulse
                    state <= DIV_IDLE;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            DIV_IDLE: begin
                if (start) begin
                    rem_sel <= want_rem;
                    zero_q  <= is_zero;
                    dvs_q   <= dvs_abs;
                    if (is_zero || is_ovf) begin
                        // Special values go straight to FIX without sign correction
                        dvd_q <= is_zero ? '1 : dividend;
                        rem_q <= is_zero ? dividend : '0;
                        q_neg <= 1'b0;
                        r_neg <= 1'b0;
                    end else begin
                        dvd_q <= dvd_abs;
                        rem_q <= '0;
                        q_neg <= signed_op & (dividend[`MULDIV_XLEN-1] ^ divisor[`MULDIV_XLEN-1]);
                        r_neg <= signed_op & dividend[`MULDIV_XLEN-1];  // Follows the dividend
                    end
                end
            end
            DIV_CALC: begin
                if (trial[`MULDIV_XLEN]) begin
                    rem_q <= rem_sh[`MULDIV_XLEN-1:0];              // Restore
                    dvd_q <= {dvd_q[`MULDIV_XLEN-2:0], 1'b0};
                end else begin
                    rem_q <= trial[`MULDIV_XLEN-1:0];
                    dvd_q <= {dvd_q[`MULDIV_XLEN-2:0], 1'b1};
                end
            end
            DIV_FIX: begin
                if (rem_sel) begin
                    result <= r_neg ? -rem_q : rem_q;
                end else begin
                    result <= q_neg ? -dvd_q : dvd_q;
                end
                div_zero <= zero_q;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/mul_mc.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_defs.svh"

module mul_mc import muldiv_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  start,
    input  xlen_t a,
    input  xlen_t b,
    input  logic  a_signed,
    input  logic  b_signed,
    input  logic  want_high,
    output logic  busy,
    output logic  done,
    output xlen_t result
);

    mul_state_e state;
    cnt_t       count;

    dxlen_t acc;                        // Upper half sums, lower half holds the multiplier
    xlen_t  mcand;                      // Multiplicand magnitude
    logic   neg;                        // Product sign
    logic   high_sel;

    logic   a_neg;
    logic   b_neg;
    xlen_t  a_abs;
    xlen_t  b_abs;
    dxlen_t prod;

    logic [`MULDIV_XLEN:0] sum;         // Carry out goes back into the accumulator

    always_comb begin
        a_neg = a_signed & a[`MULDIV_XLEN-1];
        b_neg = b_signed & b[`MULDIV_XLEN-1];
        a_abs = a_neg ? -a : a;
        b_abs = b_neg ? -b : b;
    end

    always_comb begin
        sum = {1'b0, acc[2*`MULDIV_XLEN-1:`MULDIV_XLEN]};
        if (acc[0]) begin
            sum = sum + {1'b0, mcand};  // Current multiplier bit is set
        end
        prod = neg ? -acc : acc;
    end

    assign busy = (state != MUL_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= MUL_IDLE;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                MUL_IDLE: begin
                    count <= '0;
                    if (start) begin
                        state <= MUL_CALC;
                    end
                end
                MUL_CALC: begin
                    count <= count + 1'b1;
                    if (count == cnt_t'(`MULDIV_ITER - 1)) begin
                        state <= MUL_FIX;
                    end
                end
                MUL_FIX: begin
                    done  <= 1'b1;
                    state <= MUL_IDLE;
                end
                default: state <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            MUL_IDLE: begin
                if (start) begin
                    acc      <= {{`MULDIV_XLEN{1'b0}}, b_abs};
                    mcand    <= a_abs;
                    neg      <= a_neg ^ b_neg;
                    high_sel <= want_high;
                end
            end
            MUL_CALC: begin
                acc <= {sum, acc[`MULDIV_XLEN-1:1]};    // Add then shift right
            end
            MUL_FIX: begin
                result <= high_sel ? prod[2*`MULDIV_XLEN-1:`MULDIV_XLEN]
                                   : prod[`MULDIV_XLEN-1:0];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/muldiv_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_defs.svh"

module muldiv_unit import muldiv_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start,
    input  muldiv_req_t req,
    output logic        busy,
    output logic        done,
    output muldiv_rsp_t rsp
);

    logic go;
    logic is_div;
    logic div_start;
    logic mul_start;

    logic div_signed;
    logic div_want_rem;
    logic mul_a_signed;
    logic mul_b_signed;
    logic mul_want_high;

    logic  div_busy;
    logic  div_done;
    logic  div_zero;
    xlen_t div_result;
    logic  mul_busy;
    logic  mul_done;
    xlen_t mul_result;

    muldiv_rsp_t rsp_q;                 // Last delivered response

    assign go        = start & ~busy;   // Requests during an operation are dropped
    assign is_div    = req.op[2];
    assign div_start = go & is_div;
    assign mul_start = go & ~is_div;

    always_comb begin
        div_signed    = 1'b0;
        div_want_rem  = 1'b0;
        mul_a_signed  = 1'b0;
        mul_b_signed  = 1'b0;
        mul_want_high = 1'b0;
        case (req.op)
            OP_MULH: begin
                mul_a_signed  = 1'b1;
                mul_b_signed  = 1'b1;
                mul_want_high = 1'b1;
            end
            OP_MULHSU: begin
                mul_a_signed  = 1'b1;   // rs1 signed, rs2 unsigned
                mul_want_high = 1'b1;
            end
            OP_MULHU: mul_want_high = 1'b1;
            OP_DIV:   div_signed    = 1'b1;
            OP_REM: begin
                div_signed   = 1'b1;
                div_want_rem = 1'b1;
            end
            OP_REMU:  div_want_rem  = 1'b1;
            default: ;                  // MUL and DIVU use the defaults
        endcase
    end

    div_mc u_div (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (div_start),
        .dividend  (req.a),
        .divisor   (req.b),
        .signed_op (div_signed),
        .want_rem  (div_want_rem),
        .busy      (div_busy),
        .done      (div_done),
        .result    (div_result),
        .div_zero  (div_zero)
    );

    mul_mc u_mul (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (mul_start),
        .a         (req.a),
        .b         (req.b),
        .a_signed  (mul_a_signed),
        .b_signed  (mul_b_signed),
        .want_high (mul_want_high),
        .busy      (mul_busy),
        .done      (mul_done),
        .result    (mul_result)
    );

    assign busy = div_busy | mul_busy;
    assign done = div_done | mul_done;

    // Fresh result on the done cycle, held copy otherwise
    always_comb begin
        if (div_done) begin
            rsp.result   = div_result;
            rsp.div_zero = div_zero;
        end else if (mul_done) begin
            rsp.result   = mul_result;
            rsp.div_zero = 1'b0;
        end else begin
            rsp = rsp_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_q <= '0;
        end else if (done) begin
            rsp_q <= rsp;
        end
    end

endmodule

`default_nettype wire

/* test/tb_muldiv_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_defs.svh"

module tb_muldiv_unit import muldiv_pkg::*; ();

    localparam int    TIMEOUT_EDGES = 100;
    localparam int    LAT_NORMAL    = `MULDIV_ITER + 1;   // Iteration edges plus the fix edge
    localparam int    LAT_SPECIAL   = 1;                  // Straight to the fix edge
    localparam int    NUM_RANDOM    = 400;
    localparam xlen_t MIN_NEG       = {1'b1, {(`MULDIV_XLEN-1){1'b0}}};

    logic        clk;
    logic        arst_n;
    logic        start;
    muldiv_req_t req;
    logic        busy;
    logic        done;
    muldiv_rsp_t rsp;
    integer      seed;

    muldiv_unit u_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .rsp    (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h",
                                     name, actual, expected));
        end
    endtask

    function automatic logic is_div_op(input muldiv_op_e op);
        return (op == OP_DIV) || (op == OP_DIVU) || (op == OP_REM) || (op == OP_REMU);
    endfunction

    // Reference results from wide arithmetic and the RISC-V special cases
    function automatic xlen_t model_result(input muldiv_op_e op, input xlen_t a, input xlen_t b);
        logic signed [2*`MULDIV_XLEN+1:0] ma;
        logic signed [2*`MULDIV_XLEN+1:0] mb;
        logic signed [2*`MULDIV_XLEN+1:0] prod;
        logic signed [`MULDIV_XLEN:0]     da;
        logic signed [`MULDIV_XLEN:0]     db;
        logic signed [`MULDIV_XLEN:0]     quo;
        logic signed [`MULDIV_XLEN:0]     rmd;
        logic                             sgn;
        logic                             rem_op;
        xlen_t                            res;
        if (!is_div_op(op)) begin
            sgn  = (op == OP_MULH) || (op == OP_MULHSU);   // rs1 signedness
            ma   = sgn ? {{(`MULDIV_XLEN+2){a[`MULDIV_XLEN-1]}}, a}
                       : {{(`MULDIV_XLEN+2){1'b0}}, a};
            mb   = (op == OP_MULH) ? {{(`MULDIV_XLEN+2){b[`MULDIV_XLEN-1]}}, b}
                                   : {{(`MULDIV_XLEN+2){1'b0}}, b};
            prod = ma * mb;
            res  = (op == OP_MUL) ? prod[`MULDIV_XLEN-1:0]
                                  : prod[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
        end else begin
            sgn    = (op == OP_DIV) || (op == OP_REM);
            rem_op = (op == OP_REM) || (op == OP_REMU);
            if (b == '0) begin
                res = rem_op ? a : '1;
            end else if (sgn && (a == MIN_NEG) && (b == '1)) begin
                res = rem_op ? '0 : MIN_NEG;
            end else begin
                da  = sgn ? {a[`MULDIV_XLEN-1], a} : {1'b0, a};
                db  = sgn ? {b[`MULDIV_XLEN-1], b} : {1'b0, b};
                quo = da / db;                              // Truncates toward zero
                rmd = da % db;                              // Takes the sign of the dividend
                res = rem_op ? rmd[`MULDIV_XLEN-1:0] : quo[`MULDIV_XLEN-1:0];
            end
        end
        return res;
    endfunction

    function automatic int expected_edges(input muldiv_op_e op, input xlen_t a, input xlen_t b);
        logic sgn;
        int   n;
        sgn = (op == OP_DIV) || (op == OP_REM);
        n   = LAT_NORMAL;
        if (is_div_op(op) && ((b == '0) || (sgn && (a == MIN_NEG) && (b == '1)))) begin
            n = LAT_SPECIAL;
        end
        return n;
    endfunction

    // About one operand in eight is zero, minus one or the most negative value
    function automatic xlen_t pick_operand();
        int    r;
        xlen_t v;
        r = $random(seed);
        if (r[2:0] == 3'd0) begin
            case (r[4:3])
                2'd0:    v = '0;
                2'd1:    v = '1;
                default: v = MIN_NEG;
            endcase
        end else begin
            v = $random(seed);
        end
        return v;
    endfunction

    function automatic xlen_t pick_divisor();
        xlen_t v;
        v = pick_operand();
        while (v == '0) begin
            v = pick_operand();
        end
        return v;
    endfunction

    task automatic start_op(input muldiv_op_e op, input xlen_t a, input xlen_t b);
        @(negedge clk);
        check_value("busy", busy, 1'b0);
        start  = 1'b1;
        req.op = op;
        req.a  = a;
        req.b  = b;
        @(negedge clk);                     // Start edge has passed
        start  = 1'b0;
    endtask

    // Counts rising edges after the start edge until done is seen
    task automatic wait_done(inout int edges, input muldiv_rsp_t held);
        while (!done && (edges < TIMEOUT_EDGES)) begin
            check_value("rsp.result", rsp.result, held.result);     // Previous result stays
            check_value("rsp.div_zero", rsp.div_zero, held.div_zero);
            @(negedge clk);
            edges++;
        end
        if (!done) begin
            report_failure("Timeout: done never arrived after the operation was started");
        end
    endtask

    task automatic finish_op(input muldiv_op_e op, input xlen_t a, input xlen_t b,
                             input int edges);
        xlen_t exp_result;
        logic  exp_zero;
        exp_result = model_result(op, a, b);
        exp_zero   = is_div_op(op) && (b == '0);
        check_value("done latency", edges, expected_edges(op, a, b));
        check_value("rsp.result", rsp.result, exp_result);
        check_value("rsp.div_zero", rsp.div_zero, exp_zero);
        @(negedge clk);
        check_value("done", done, 1'b0);    // Single-cycle pulse
        check_value("busy", busy, 1'b0);
        check_value("rsp.result", rsp.result, exp_result);
    endtask

    task automatic run_op(input muldiv_op_e op, input xlen_t a, input xlen_t b);
        int          edges;
        muldiv_rsp_t prev;
        prev = rsp;
        start_op(op, a, b);
        check_value("busy", busy, 1'b1);
        edges = 0;
        wait_done(edges, prev);
        finish_op(op, a, b, edges);
    endtask

    // Response must stay put while the request inputs wander with start low
    task automatic check_hold(input int cycles);
        muldiv_rsp_t held;
        int          r;
        held = rsp;
        repeat (cycles) begin
            @(negedge clk);
            check_value("rsp.result", rsp.result, held.result);
            check_value("rsp.div_zero", rsp.div_zero, held.div_zero);
            check_value("done", done, 1'b0);
            check_value("busy", busy, 1'b0);
            r      = $random(seed);
            req.op = muldiv_op_e'(r[2:0]);
            req.a  = $random(seed);
            req.b  = $random(seed);
        end
    endtask

    // A second start while busy must leave the first operation untouched
    task automatic ignore_check(input muldiv_op_e op1, input xlen_t a1, input xlen_t b1,
                                input muldiv_op_e op2, input xlen_t a2, input xlen_t b2);
        int          edges;
        muldiv_rsp_t prev;
        prev = rsp;
        start_op(op1, a1, b1);
        edges = 0;
        repeat (3) begin
            @(negedge clk);
            edges++;
        end
        check_value("busy", busy, 1'b1);
        start  = 1'b1;
        req.op = op2;
        req.a  = a2;
        req.b  = b2;
        @(negedge clk);
        edges++;
        start  = 1'b0;
        wait_done(edges, prev);
        finish_op(op1, a1, b1, edges);
        check_hold(4);                      // No late done from the dropped request
    endtask

    initial begin
        int         i;
        int         r;
        muldiv_op_e op;
        xlen_t      a;
        xlen_t      b;
        seed   = 85;
        arst_n = 1'b0;
        start  = 1'b0;
        req    = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        check_value("busy", busy, 1'b0);
        check_value("done", done, 1'b0);
        check_value("rsp", rsp, '0);

        for (i = 0; i < NUM_RANDOM; i++) begin
            r  = $random(seed);
            op = muldiv_op_e'({1'b0, r[1:0]});
            run_op(op, pick_operand(), pick_operand());
        end
        check_hold(6);

        for (i = 0; i < NUM_RANDOM; i++) begin
            r  = $random(seed);
            op = muldiv_op_e'({1'b1, r[1:0]});
            run_op(op, pick_operand(), pick_divisor());
        end
        check_hold(6);

        // Division by zero with random and corner dividends
        for (i = 0; i < 10; i++) begin
            a = (i == 0) ? MIN_NEG : (i == 1) ? '0 : pick_operand();
            run_op(OP_DIV, a, '0);
            run_op(OP_DIVU, a, '0);
            run_op(OP_REM, a, '0);
            run_op(OP_REMU, a, '0);
        end
        check_hold(6);

        run_op(OP_DIV, MIN_NEG, '1);        // Signed overflow
        run_op(OP_REM, MIN_NEG, '1);
        run_op(OP_DIVU, MIN_NEG, '1);       // Plain unsigned case
        run_op(OP_REMU, MIN_NEG, '1);
        check_hold(6);

        a = pick_operand();
        b = pick_operand();
        ignore_check(OP_MULHSU, a, b, OP_DIV, pick_operand(), '0);
        a = pick_operand();
        b = pick_divisor();
        ignore_check(OP_REM, a, xlen_t'(7), OP_MUL, b, pick_operand());
        ignore_check(OP_DIVU, pick_operand(), b, OP_REMU, a, b);

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+rtl
rtl/muldiv_pkg.sv
rtl/div_mc.sv
rtl/mul_mc.sv
rtl/muldiv_unit.sv
test/tb_muldiv_unit.sv

/* Bender.yml */
package:
  name: muldiv_unit

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/muldiv_pkg.sv
      - rtl/div_mc.sv
      - rtl/mul_mc.sv
      - rtl/muldiv_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_muldiv_unit.sv
